/* uart_pkg.sv */
package uart_pkg;

    // register offsets inside the 4 KB window
    localparam logic [11:0] ADDR_TXDATA  = 12'h000;
    localparam logic [11:0] ADDR_STATUS  = 12'h004;
    localparam logic [11:0] ADDR_DIVISOR = 12'h008;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    localparam logic [15:0] DIV_RESET = 16'd16;  // clocks per bit out of reset
    localparam logic [15:0] DIV_MIN   = 16'd2;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one register access, handed from the bus side to the register block
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } reg_rsp_t;

    typedef enum logic [2:0] {
        OP_TX_PUSH,
        OP_STATUS_RD,
        OP_DIV_RD,
        OP_DIV_WR,
        OP_ZERO_RD,
        OP_NOP_WR,
        OP_BAD
    } reg_op_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_RESP
    } slave_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

/* uart_axi_slave.sv */
module uart_axi_slave (
    input  logic               clk,
    input  logic               rst,

    input  logic [31:0]        araddr,
    input  logic               arvalid,
    output logic               arready,

    output logic [31:0]        rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,

    input  logic [31:0]        awaddr,
    input  logic               awvalid,
    output logic               awready,

    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,

    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,

    output uart_pkg::reg_req_t req,
    input  uart_pkg::reg_rsp_t rsp
);
    import uart_pkg::*;

    slave_state_e state;
    logic         aw_got;      // write address already accepted
    logic         w_got;       // write data already accepted
    logic         is_write;
    logic [11:0]  addr_q;
    logic [31:0]  wdata_q;
    logic [3:0]   wstrb_q;
    logic         ar_take;
    logic         aw_take;
    logic         w_take;
    logic         wr_ready;
    logic         rsp_load;

    // a half-received write keeps reads out so the two never interleave
    assign arready = (state == S_IDLE) && !aw_got && !w_got;
    assign ar_take = arvalid && arready;

    // on a tie the read wins and the write channels wait a turn
    assign awready = (state == S_IDLE) && !aw_got && !ar_take;
    assign wready  = (state == S_IDLE) && !w_got && !ar_take;
    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;

    assign wr_ready = (aw_got || aw_take) && (w_got || w_take);  // both halves in hand
    assign rsp_load = (state == S_RESP) && !rvalid && !bvalid;   // regs answer is ready now

    always_comb begin
        req.valid = (state == S_EXEC);
        req.write = is_write;
        req.addr  = addr_q;
        req.wdata = wdata_q;
        req.wstrb = wstrb_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            is_write <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ar_take) begin
                        is_write <= 1'b0;
                        state    <= S_EXEC;
                    end else if (wr_ready) begin
                        is_write <= 1'b1;
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                        state    <= S_EXEC;
                    end else begin
                        aw_got <= aw_got || aw_take;
                        w_got  <= w_got || w_take;
                    end
                end
                S_EXEC: state <= S_RESP;  // request is seen by the regs on this edge
                S_RESP: begin
                    if (rsp_load) begin
                        rvalid <= !is_write;
                        bvalid <= is_write;
                    end else if ((rvalid && rready) || (bvalid && bready)) begin
                        rvalid <= 1'b0;
                        bvalid <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_take) begin
            addr_q <= araddr[11:0];
        end else if (aw_take) begin
            addr_q <= awaddr[11:0];
        end
        if (w_take) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        // payload is frozen once valid is up, so back-pressure cannot disturb it
        if (rsp_load) begin
            if (is_write) begin
                bresp <= rsp.err ? RESP_SLVERR : RESP_OKAY;
            end else begin
                rdata <= rsp.rdata;
                rresp <= rsp.err ? RESP_SLVERR : RESP_OKAY;
            end
        end
    end

endmodule

/* uart_reg_decode.sv */
module uart_reg_decode (
    input  uart_pkg::reg_req_t req,
    output uart_pkg::reg_op_e  op
);
    import uart_pkg::*;

    // unaligned offsets never match a register, so the default catches them
    always_comb begin
        case (req.addr)
            ADDR_TXDATA: begin
                if (!req.write) begin
                    op = OP_ZERO_RD;
                end else if (req.wstrb[0]) begin
                    op = OP_TX_PUSH;
                end else begin
                    op = OP_BAD;  // no byte lane carries the character
                end
            end
            ADDR_STATUS: begin
                if (req.write) begin
                    op = OP_NOP_WR;
                end else begin
                    op = OP_STATUS_RD;
                end
            end
            ADDR_DIVISOR: begin
                if (!req.write) begin
                    op = OP_DIV_RD;
                end else if (&req.wstrb[1:0]) begin
                    op = OP_DIV_WR;
                end else begin
                    // a half-written divisor would leave a meaningless rate
                    op = OP_BAD;
                end
            end
            default: op = OP_BAD;
        endcase
    end

endmodule

/* uart_regs.sv */
module uart_regs (
    input  logic               clk,
    input  logic               rst,
    input  uart_pkg::reg_req_t req,
    input  uart_pkg::reg_op_e  op,
    output uart_pkg::reg_rsp_t rsp,
    output logic               push,
    output logic [7:0]         push_data,
    input  logic               fifo_full,
    input  logic               fifo_empty,
    input  logic               tx_busy,
    output logic [15:0]        divisor
);
    import uart_pkg::*;

    reg_rsp_t rsp_next;
    logic     div_ok;

    assign div_ok = req.wdata[15:0] >= DIV_MIN;

    // byte goes into the FIFO on the same edge that registers the response
    assign push      = req.valid && (op == OP_TX_PUSH) && !fifo_full;
    assign push_data = req.wdata[7:0];

    always_comb begin
        rsp_next = '0;
        case (op)
            OP_TX_PUSH: begin
                rsp_next.err = fifo_full;  // byte is dropped when there is no room
            end
            OP_STATUS_RD: begin
                rsp_next.rdata = {29'd0, tx_busy, fifo_empty, fifo_full};
            end
            OP_DIV_RD: begin
                rsp_next.rdata = {16'd0, divisor};
            end
            OP_DIV_WR: begin
                rsp_next.err = !div_ok;
            end
            OP_ZERO_RD: begin
                rsp_next = '0;
            end
            OP_NOP_WR: begin
                rsp_next = '0;
            end
            default: begin
                rsp_next.err = 1'b1;  // illegal access reads back zero
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            divisor <= DIV_RESET;
        end else if (req.valid && (op == OP_DIV_WR) && div_ok) begin
            divisor <= req.wdata[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp <= rsp_next;
        end
    end

endmodule

/* uart_tx_fifo.sv */
module uart_tx_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);
    import uart_pkg::*;

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;  // one bit wider so that full fits
    logic               do_push;
    logic               do_pop;

    assign full     = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];  // head is visible before the pop

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* uart_tx.sv */
module uart_tx (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] divisor,
    input  logic        fifo_empty,
    input  logic [7:0]  pop_data,
    output logic        pop,
    output logic        busy,
    output logic        tx
);
    import uart_pkg::*;

    tx_state_e   state;
    logic [15:0] clk_cnt;   // clocks spent in the current bit
    logic [2:0]  bit_cnt;
    logic [7:0]  shift;
    logic [15:0] div_q;     // rate held for the whole frame
    logic        bit_end;

    assign bit_end = (clk_cnt == div_q - 16'd1);

    // the last stop-bit clock can pop too, so frames run back to back
    assign pop  = !fifo_empty && ((state == TX_IDLE) || ((state == TX_STOP) && bit_end));
    assign busy = (state != TX_IDLE);

    always_comb begin
        case (state)
            TX_START: tx = 1'b0;
            TX_DATA:  tx = shift[0];  // LSB first
            default:  tx = 1'b1;      // idle and stop bit
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (pop) begin
            state   <= TX_START;
            clk_cnt <= '0;
        end else if (state != TX_IDLE) begin
            if (!bit_end) begin
                clk_cnt <= clk_cnt + 16'd1;
            end else begin
                clk_cnt <= '0;
                case (state)
                    TX_START: begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                    end
                    TX_DATA: begin
                        if (bit_cnt == 3'd7) begin
                            state <= TX_STOP;
                        end
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                    default: state <= TX_IDLE;  // stop bit done and nothing queued
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= pop_data;
            div_q <= divisor;
        end else if ((state == TX_DATA) && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule

/* uart_top.sv */
module uart_top (
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,

    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,

    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,

    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,

    output logic        tx
);
    import uart_pkg::*;

    reg_req_t    req;
    reg_rsp_t    rsp;
    reg_op_e     op;
    logic        push;
    logic [7:0]  push_data;
    logic        pop;
    logic [7:0]  pop_data;
    logic        fifo_full;
    logic        fifo_empty;
    logic        tx_busy;
    logic [15:0] divisor;

    uart_axi_slave u_slave (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .req     (req),
        .rsp     (rsp)
    );

    uart_reg_decode u_decode (
        .req (req),
        .op  (op)
    );

    uart_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .rsp        (rsp),
        .push       (push),
        .push_data  (push_data),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .tx_busy    (tx_busy),
        .divisor    (divisor)
    );

    uart_tx_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .divisor    (divisor),
        .fifo_empty (fifo_empty),
        .pop_data   (pop_data),
        .pop        (pop),
        .busy       (tx_busy),
        .tx         (tx)
    );

endmodule

/* tb_uart.sv */
module tb_uart;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [11:0] TXDATA_OFS  = 12'h000;
    localparam logic [11:0] STATUS_OFS  = 12'h004;
    localparam logic [11:0] DIVISOR_OFS = 12'h008;
    localparam logic [1:0]  OKAY        = 2'b00;
    localparam logic [1:0]  SLVERR      = 2'b10;
    // longest test is 12 frames of 160 clocks, the rest is bus traffic and margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk;
    logic        rst;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        tx;

    integer      seed;
    int          errors;
    int          cycles;
    string       test_name;
    logic [15:0] mon_div;  // rate the line decoder expects
    logic [7:0]  exp_q[$];
    logic [7:0]  rx_q[$];

    uart_top dut (.*);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("mismatch in %s: %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    function automatic logic [15:0] rand_div();
        return 16'(32'd2 + ($unsigned($random(seed)) % 32'd39));
    endfunction

    task automatic collect_response(input bit is_read, input int stall,
                                    output logic [31:0] data, output logic [1:0] resp);
        int i;
        @(negedge clk);
        while (!(is_read ? rvalid : bvalid)) @(negedge clk);
        data = is_read ? rdata : 32'd0;
        resp = is_read ? rresp : bresp;
        for (i = 0; i < stall; i++) begin
            @(negedge clk);  // ready is still low here
            check("valid held", 1, 32'(is_read ? rvalid : bvalid));
            check("response held", 32'(resp), 32'(is_read ? rresp : bresp));
            if (is_read) begin
                check("read data held", data, rdata);
            end
        end
        if (stall > 0) begin
            @(posedge clk);
            #2;
            if (is_read) begin
                rready = 1'b1;
            end else begin
                bready = 1'b1;
            end
        end
        @(posedge clk);  // the response transfers on this edge
        #2;
        rready = 1'b0;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        #2;
        araddr  = {20'd0, addr};
        arvalid = 1'b1;
        rready  = (stall == 0);
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        collect_response(1'b1, stall, data, resp);
    endtask

    // holds each valid until its ready was seen high ahead of an edge
    task automatic accept_write_channels();
        logic aw_go;
        logic w_go;
        while (awvalid || wvalid) begin
            @(negedge clk);
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            @(posedge clk);
            #2;
            if (aw_go) begin
                awvalid = 1'b0;
            end
            if (w_go) begin
                wvalid = 1'b0;
            end
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input bit w_first, input int stall,
                             output logic [1:0] resp);
        logic [31:0] no_data;
        @(posedge clk);
        #2;
        awaddr = {20'd0, addr};
        wdata  = data;
        wstrb  = strb;
        bready = (stall == 0);
        wvalid = 1'b1;
        if (w_first) begin
            accept_write_channels();  // data beat lands before the address is offered
        end
        awvalid = 1'b1;
        accept_write_channels();
        collect_response(1'b0, stall, no_data, resp);
    endtask

    task automatic expect_read(input logic [11:0] addr, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp, input int stall);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, stall, data, resp);
        check($sformatf("read %03h data", addr), exp_data, data);
        check($sformatf("read %03h resp", addr), 32'(exp_resp), 32'(resp));
    endtask

    task automatic expect_write(input logic [11:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input bit w_first, input int stall,
                                input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, strb, w_first, stall, resp);
        check($sformatf("write %03h resp", addr), 32'(exp_resp), 32'(resp));
    endtask

    task automatic set_divisor(input logic [15:0] d, input bit w_first, input int stall);
        expect_write(DIVISOR_OFS, 32'(d), 4'hf, w_first, stall, OKAY);
        mon_div = d;
    endtask

    // samples each bit in its middle, counting from the first low sample of the start bit
    task automatic receive_frame();
        logic [7:0]  b;
        logic [15:0] d;
        int          i;
        @(negedge clk);
        while (tx !== 1'b0) @(negedge clk);
        d = mon_div;
        repeat (d / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            errors++;
            $display("start bit on tx did not stay low for half a bit time");
        end
        for (i = 0; i < 8; i++) begin
            repeat (d) @(negedge clk);
            b[i] = tx;
        end
        repeat (d) @(negedge clk);
        if (tx !== 1'b1) begin
            errors++;
            $display("stop bit on tx was low, frame is broken");
        end
        rx_q.push_back(b);
    endtask

    task automatic wait_tx_idle();
        logic [31:0] st;
        logic [1:0]  resp;
        st = 32'd0;
        while (st != 32'd2) begin
            axi_read(STATUS_OFS, 0, st, resp);
        end
        check("tx line idle", 1, 32'(tx));
    endtask

    task automatic compare_streams();
        int i;
        check("bytes on tx", exp_q.size(), rx_q.size());
        for (i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check($sformatf("byte %0d on tx", i), 32'(exp_q[i]), 32'(rx_q[i]));
        end
        exp_q.delete();
        rx_q.delete();
    endtask

    task automatic test_reset_state();
        test_name = "reset state";
        expect_read(STATUS_OFS, 32'd2, OKAY, 0);
        expect_read(DIVISOR_OFS, 32'd16, OKAY, 0);
        check("tx line", 1, 32'(tx));
    endtask

    task automatic test_divisor();
        logic [15:0] d;
        test_name = "divisor register";
        d = rand_div();
        set_divisor(d, 1'b0, 0);
        expect_read(DIVISOR_OFS, 32'(d), OKAY, 0);
        expect_write(DIVISOR_OFS, 32'd1, 4'hf, 1'b0, 0, SLVERR);
        expect_read(DIVISOR_OFS, 32'(d), OKAY, 0);  // refused value leaves the old one
        d = rand_div();
        set_divisor(d, 1'b1, 0);
        expect_read(DIVISOR_OFS, 32'(d), OKAY, 0);
        expect_write(DIVISOR_OFS, 32'd1, 4'hf, 1'b1, 0, SLVERR);
        expect_read(DIVISOR_OFS, 32'(d), OKAY, 0);
    endtask

    task automatic test_single_byte();
        logic [7:0] b;
        test_name = "single byte";
        set_divisor(16'd8, 1'b0, 0);
        b = 8'($random(seed));
        expect_write(TXDATA_OFS, {24'd0, b}, 4'h1, 1'b0, 0, OKAY);
        exp_q.push_back(b);
        wait_tx_idle();
        compare_streams();
    endtask

    task automatic test_fifo_fill();
        logic [7:0]  b;
        logic [31:0] st;
        logic [1:0]  resp;
        int          n;
        test_name = "fifo fill";
        set_divisor(16'd16, 1'b0, 0);
        st = 32'd0;
        n = 0;
        // one byte leaves for the serializer at once, so nine fit before full
        while (!st[0] && n < 12) begin
            b = 8'($random(seed));
            expect_write(TXDATA_OFS, {24'd0, b}, 4'h1, 1'b0, 0, OKAY);
            exp_q.push_back(b);
            axi_read(STATUS_OFS, 0, st, resp);
            n++;
        end
        check("fifo full flag", 1, 32'(st[0]));
        b = 8'($random(seed));
        expect_write(TXDATA_OFS, {24'd0, b}, 4'h1, 1'b0, 0, SLVERR);
        wait_tx_idle();
        compare_streams();
    endtask

    task automatic test_illegal();
        test_name = "illegal accesses";
        expect_read(12'h00C, 32'd0, SLVERR, 0);
        expect_read(12'h002, 32'd0, SLVERR, 0);
        expect_write(TXDATA_OFS, 32'h55, 4'b1110, 1'b0, 0, SLVERR);
        expect_write(12'h010, 32'h1234, 4'hf, 1'b0, 0, SLVERR);
        expect_read(TXDATA_OFS, 32'd0, OKAY, 0);
        expect_read(STATUS_OFS, 32'd2, OKAY, 0);  // nothing was queued
        repeat (10 * mon_div) @(posedge clk);  // a stray frame would have reached the decoder
        compare_streams();
    endtask

    task automatic test_backpressure();
        logic [15:0] d;
        test_name = "back-pressure";
        expect_read(DIVISOR_OFS, 32'(mon_div), OKAY, 1 + ($unsigned($random(seed)) % 10));
        d = rand_div();
        set_divisor(d, 1'b0, 1 + ($unsigned($random(seed)) % 10));
        expect_read(DIVISOR_OFS, 32'(d), OKAY, 1 + ($unsigned($random(seed)) % 10));
        @(negedge clk);
        check("arready after response", 1, 32'(arready));
        check("awready after response", 1, 32'(awready));
        check("wready after response", 1, 32'(wready));
    endtask

    initial begin
        @(negedge rst);
        forever receive_frame();
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the tests did not end within %0d cycles", cycles);
        $display("error count: %0d", errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed    = 37;
        errors  = 0;
        mon_div = 16'd16;
        rst     = 1'b1;
        araddr  = 32'd0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = 32'd0;
        awvalid = 1'b0;
        wdata   = 32'd0;
        wstrb   = 4'd0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_state();
        test_divisor();
        test_single_byte();
        test_fifo_fill();
        test_illegal();
        test_backpressure();
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* project.f */
uart_pkg.sv
uart_axi_slave.sv
uart_reg_decode.sv
uart_regs.sv
uart_tx_fifo.sv
uart_tx.sv
uart_top.sv
tb_uart.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and decides pass or fail from the log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_uart -f project.f \
    -o sim_uart > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_uart > sim.log 2>&1 || echo "simulator returned an error status"
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
